// File: cplxAluPkg.sv
`default_nettype none

package cplxAluPkg;

    localparam int DATA_W    = 32;  // operand and result width
    localparam int TAG_W     = 7;   // destination tag width
    localparam int ALU_DEPTH = 4;   // issue to writeback latency in edges

    // issue opcodes of the long-latency unit
    typedef enum logic [3:0] {
        MUL_L   = 4'h0,  // signed product low word
        MUL_H   = 4'h1,  // signed product high word
        MULU_L  = 4'h2,  // unsigned product low word
        MULU_H  = 4'h3,  // unsigned product high word
        DIV     = 4'h4,  // signed quotient
        REM     = 4'h5,  // signed remainder
        DIVU    = 4'h6,  // unsigned quotient
        REMU    = 4'h7,  // unsigned remainder
        SYSCALL = 4'h8   // trap only
    } opcode_e;          // 4'h9 and up are illegal

    // which unit output lands in destData
    typedef enum logic [2:0] {
        SEL_MUL_LO = 3'h0,
        SEL_MUL_HI = 3'h1,
        SEL_QUOT   = 3'h2,
        SEL_REM    = 3'h3,
        SEL_NONE   = 3'h4   // no result so data is forced to 0
    } resultSel_e;

    typedef struct packed {
        logic executed;   // always set on completion
        logic exception;  // div by zero, syscall, illegal
        logic destValid;  // result goes to the register file
    } exeFlags_t;

    // 76 bit packet from the issue queue
    typedef struct packed {
        logic              valid;
        opcode_e           opcode;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data1;
        logic [DATA_W-1:0] data2;
    } issuePkt_t;

    // 14 bit decoded control riding the delay line
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        resultSel_e       resultSel;
        exeFlags_t        flags;
    } ctrlPkt_t;

    // 43 bit writeback to the register file and active list
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        exeFlags_t         flags;
        logic [DATA_W-1:0] destData;
    } wbPkt_t;

endpackage

`default_nettype wire

// File: cplxAluTop.sv
`default_nettype none
`timescale 1ns/1ps

module cplxAluTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   recover_i,
    input  cplxAluPkg::issuePkt_t  issue_i,
    output cplxAluPkg::wbPkt_t     wb_o
);
    import cplxAluPkg::*;

    ctrlPkt_t          ctrl;       // decoded control into the delay line
    logic              mulSigned;
    logic              divSigned;
    logic              divByZero;
    logic [DATA_W-1:0] divisor;    // guarded, never zero
    logic [DATA_W-1:0] productLo;
    logic [DATA_W-1:0] productHi;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    opDecoder iDecoder (
        .issue_i     (issue_i),
        .ctrl_o      (ctrl),
        .mulSigned_o (mulSigned),
        .divSigned_o (divSigned),
        .divisor_o   (divisor),
        .divByZero_o (divByZero)
    );

    mulUnit iMul (
        .clk         (clk),
        .data1_i     (issue_i.data1),
        .data2_i     (issue_i.data2),
        .mulSigned_i (mulSigned),
        .productLo_o (productLo),
        .productHi_o (productHi)
    );

    divUnit iDiv (
        .clk         (clk),
        .data1_i     (issue_i.data1),
        .divisor_i   (divisor),
        .divSigned_i (divSigned),
        .divByZero_i (divByZero),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    writebackPipe iWbPipe (
        .clk         (clk),
        .reset       (reset),
        .recover_i   (recover_i),
        .ctrl_i      (ctrl),
        .productLo_i (productLo),
        .productHi_i (productHi),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .wb_o        (wb_o)
    );

endmodule

`default_nettype wire

// File: divUnit.sv
`default_nettype none
`timescale 1ns/1ps

module divUnit (
    input  logic                           clk,
    input  logic [cplxAluPkg::DATA_W-1:0]  data1_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  divisor_i,
    input  logic                           divSigned_i,
    input  logic                           divByZero_i,
    output logic [cplxAluPkg::DATA_W-1:0]  quotient_o,
    output logic [cplxAluPkg::DATA_W-1:0]  remainder_o
);
    import cplxAluPkg::*;

    typedef struct packed {
        logic [DATA_W-1:0] quot;
        logic [DATA_W-1:0] rem;
    } divRes_t;

    logic              dividendNeg;  // only in signed mode
    logic              divisorNeg;
    logic              overflow;     // most negative by -1
    logic [DATA_W-1:0] magA;
    logic [DATA_W-1:0] magB;
    logic [DATA_W-1:0] magQuot;
    logic [DATA_W-1:0] magRem;
    divRes_t           result;
    divRes_t           resPipe [ALU_DEPTH];  // result delay line

    assign dividendNeg = divSigned_i & data1_i[DATA_W-1];
    assign divisorNeg  = divSigned_i & divisor_i[DATA_W-1];

    // 0x8000_0000 maps onto itself as an unsigned magnitude
    assign magA = dividendNeg ? -data1_i   : data1_i;
    assign magB = divisorNeg  ? -divisor_i : divisor_i;

    assign magQuot = magA / magB;  // magB never zero
    assign magRem  = magA % magB;

    assign overflow = dividendNeg && (data1_i[DATA_W-2:0] == '0) && (divisor_i == '1);

    always_comb
    begin
        // truncation toward zero
        result.quot = (dividendNeg ^ divisorNeg) ? -magQuot : magQuot;
        result.rem  = dividendNeg ? -magRem : magRem;  // sign of the dividend
        if (overflow)
        begin
            result.quot = data1_i;  // most negative value comes back
            result.rem  = '0;
        end
        if (divByZero_i)
        begin
            result = '0;  // trap returns 0 in both words
        end
    end

    always_ff @(posedge clk)
    begin
        resPipe[0] <= result;
        for (int i = 1; i < ALU_DEPTH; i++)
        begin
            resPipe[i] <= resPipe[i-1];
        end
    end

    assign quotient_o  = resPipe[ALU_DEPTH-1].quot;
    assign remainder_o = resPipe[ALU_DEPTH-1].rem;

    // the decoder guards the divisor
    assert property (@(posedge clk) divisor_i != '0)
        else $error("divUnit: zero divisor reached the divider");

endmodule

`default_nettype wire

// File: list.f
cplxAluPkg.sv
opDecoder.sv
mulUnit.sv
divUnit.sv
writebackPipe.sv
cplxAluTop.sv
tb_cplxAlu.sv

// File: mulUnit.sv
`default_nettype none
`timescale 1ns/1ps

module mulUnit (
    input  logic                           clk,
    input  logic [cplxAluPkg::DATA_W-1:0]  data1_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  data2_i,
    input  logic                           mulSigned_i,
    output logic [cplxAluPkg::DATA_W-1:0]  productLo_o,
    output logic [cplxAluPkg::DATA_W-1:0]  productHi_o
);
    import cplxAluPkg::*;

    logic signed [DATA_W:0]     opA;  // 33 bit extended operand
    logic signed [DATA_W:0]     opB;
    logic        [2*DATA_W-1:0] product;
    logic        [2*DATA_W-1:0] prodPipe [ALU_DEPTH];  // product delay line

    // top bit is the sign in signed mode and zero otherwise
    assign opA = {mulSigned_i & data1_i[DATA_W-1], data1_i};
    assign opB = {mulSigned_i & data2_i[DATA_W-1], data2_i};

    // one shared signed multiplier covers both modes
    assign product = (2*DATA_W)'(opA) * (2*DATA_W)'(opB);  // low 64 bits are exact

    always_ff @(posedge clk)
    begin
        prodPipe[0] <= product;  // captured at issue
        for (int i = 1; i < ALU_DEPTH; i++)
        begin
            prodPipe[i] <= prodPipe[i-1];  // aligned with the ctrl delay line
        end
    end

    assign {productHi_o, productLo_o} = prodPipe[ALU_DEPTH-1];

endmodule

`default_nettype wire

// File: opDecoder.sv
`default_nettype none
`timescale 1ns/1ps

module opDecoder (
    input  cplxAluPkg::issuePkt_t          issue_i,
    output cplxAluPkg::ctrlPkt_t           ctrl_o,
    output logic                           mulSigned_o,
    output logic                           divSigned_o,
    output logic [cplxAluPkg::DATA_W-1:0]  divisor_o,
    output logic                           divByZero_o
);
    import cplxAluPkg::*;

    logic isDivide;     // one of the four divide forms
    logic zeroDivisor;  // raw data2 is zero

    assign zeroDivisor = (issue_i.data2 == '0);

    always_comb
    begin
        ctrl_o                = '0;
        ctrl_o.valid          = issue_i.valid;
        ctrl_o.tag            = issue_i.tag;
        ctrl_o.resultSel      = SEL_NONE;
        ctrl_o.flags.executed = 1'b1;  // every opcode completes
        mulSigned_o           = 1'b0;
        divSigned_o           = 1'b0;
        isDivide              = 1'b0;

        case (issue_i.opcode)
            MUL_L, MUL_H, MULU_L, MULU_H:
            begin
                ctrl_o.flags.destValid = 1'b1;
                mulSigned_o            = (issue_i.opcode inside {MUL_L, MUL_H});
                ctrl_o.resultSel       = (issue_i.opcode inside {MUL_L, MULU_L}) ?
                                         SEL_MUL_LO : SEL_MUL_HI;
            end
            DIV, REM, DIVU, REMU:
            begin
                isDivide               = 1'b1;
                ctrl_o.flags.destValid = 1'b1;  // still writes 0 on a trap
                ctrl_o.flags.exception = zeroDivisor;
                divSigned_o            = (issue_i.opcode inside {DIV, REM});
                ctrl_o.resultSel       = (issue_i.opcode inside {DIV, DIVU}) ?
                                         SEL_QUOT : SEL_REM;
            end
            SYSCALL: ctrl_o.flags.exception = 1'b1;  // trap with no destination
            default: ctrl_o.flags.exception = 1'b1;  // illegal code
        endcase
    end

    // divider only ever sees a nonzero divisor
    assign divisor_o   = (isDivide && !zeroDivisor) ? issue_i.data2 : DATA_W'(1);
    assign divByZero_o = isDivide && zeroDivisor;  // tells the divider to return 0

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cplxAlu

verilator --binary --timing --assert --top-module "$TOP" -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -F -q "*** FAILED ***" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: tb_cplxAlu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cplxAlu;
    import cplxAluPkg::*;

    localparam int PERIOD  = 4;            // ns
    localparam int NUM_OPS = 120;          // issue budget that also sizes the watchdog
    localparam int N_RAND  = NUM_OPS / 3;  // random ops per unit

    // expected writeback plus the edge that sampled its issue
    typedef struct packed {
        wbPkt_t      pkt;
        int unsigned issueEdge;
    } expEntry_t;

    logic             clk      = 1'b0;
    logic             reset    = 1'b1;
    logic             recover  = 1'b0;
    issuePkt_t        issuePkt = '0;
    wbPkt_t           wb;
    int unsigned      cycle    = 0;     // edge counter
    int               seed     = 38;
    int               errCount = 0;
    logic [TAG_W-1:0] nextTag  = '0;
    expEntry_t        expQ[$];          // in-flight expectations in issue order
    logic             expValid = 1'b0;  // a writeback is due this cycle
    wbPkt_t           expPkt   = '0;

    cplxAluTop i_dut (
        .clk       (clk),
        .reset     (reset),
        .recover_i (recover),
        .issue_i   (issuePkt),
        .wb_o      (wb)
    );

    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // writeback value straight from the arithmetic rules
    function automatic wbPkt_t refResult(input issuePkt_t p);
        wbPkt_t              r;
        logic                sgn;
        logic [2*DATA_W-1:0] a64;
        logic [2*DATA_W-1:0] b64;
        logic [2*DATA_W-1:0] prod;
        int                  sa;
        int                  sb;
        r                = '0;
        r.valid          = 1'b1;
        r.tag            = p.tag;
        r.flags.executed = 1'b1;
        sa               = p.data1;
        sb               = p.data2;
        sgn              = p.opcode inside {MUL_L, MUL_H};
        case (p.opcode)
            MUL_L, MUL_H, MULU_L, MULU_H:
            begin
                a64  = {{DATA_W{sgn & p.data1[DATA_W-1]}}, p.data1};  // extend to 64
                b64  = {{DATA_W{sgn & p.data2[DATA_W-1]}}, p.data2};
                prod = a64 * b64;
                r.flags.destValid = 1'b1;
                r.destData = (p.opcode inside {MUL_L, MULU_L}) ? prod[DATA_W-1:0]
                                                               : prod[2*DATA_W-1:DATA_W];
            end
            DIV, REM:
            begin
                r.flags.destValid = 1'b1;
                if (p.data2 == '0)
                    r.flags.exception = 1'b1;  // data stays 0
                else if (p.data1 == 32'h8000_0000 && p.data2 == 32'hFFFF_FFFF)
                    r.destData = (p.opcode == DIV) ? p.data1 : '0;  // overflow rule
                else
                    r.destData = (p.opcode == DIV) ? sa / sb : sa % sb;  // toward zero
            end
            DIVU, REMU:
            begin
                r.flags.destValid = 1'b1;
                if (p.data2 == '0)
                    r.flags.exception = 1'b1;
                else
                    r.destData = (p.opcode == DIVU) ? p.data1 / p.data2 : p.data1 % p.data2;
            end
            default: r.flags.exception = 1'b1;  // syscall or illegal with no dest
        endcase
        return r;
    endfunction

    // corner values show up often
    function automatic logic [DATA_W-1:0] pickOperand();
        int r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h8000_0000;  // most negative
            3'd1:    return 32'hFFFF_FFFF;  // all ones
            3'd2:    return '0;
            3'd3:    return 32'd7;
            default: return $random(seed);
        endcase
    endfunction

    function automatic issuePkt_t buildPkt(input opcode_e op, input logic [DATA_W-1:0] a,
                                          input logic [DATA_W-1:0] b);
        issuePkt_t p;
        p.valid  = 1'b1;
        p.opcode = op;
        p.tag    = nextTag;
        p.data1  = a;
        p.data2  = b;
        return p;
    endfunction

    task automatic issueOp(input opcode_e op, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
        issuePkt_t p;
        expEntry_t e;
        @(posedge clk);
        p         = buildPkt(op, a, b);
        issuePkt <= p;
        recover  <= 1'b0;
        e.pkt       = refResult(p);
        e.issueEdge = cycle + 1;  // DUT samples it on the next edge
        expQ.push_back(e);
        nextTag++;
    endtask

    // recovery pulse that kills the in-flight packets and the one alongside
    task automatic recoverWith(input opcode_e op, input logic [DATA_W-1:0] a,
                               input logic [DATA_W-1:0] b);
        @(posedge clk);
        issuePkt <= buildPkt(op, a, b);
        recover  <= 1'b1;
        for (int i = expQ.size() - 1; i >= 0; i--)
        begin
            if (expQ[i].issueEdge + ALU_DEPTH > cycle + 1)
                expQ.delete(i);  // still in flight at the pulse
        end
        nextTag++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            issuePkt <= '0;
            recover  <= 1'b0;
        end
    endtask

    // load the expectation for the cycle after this edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            expValid <= 1'b0;
            expPkt   <= '0;
        end
        else if (expQ.size() > 0 && expQ[0].issueEdge + ALU_DEPTH == cycle + 1)
        begin
            expValid <= 1'b1;
            expPkt   <= expQ[0].pkt;
            expQ.pop_front();
        end
        else
        begin
            expValid <= 1'b0;
            expPkt   <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (reset) expValid |-> wb == expPkt)
        else
        begin
            errCount++;
            $display("ERR %0t: writeback %h, expected %h", $time, wb, expPkt);
        end

    assert property (@(posedge clk) disable iff (reset) !expValid |-> !wb.valid)
        else
        begin
            errCount++;
            $display("ERR %0t: unexpected writeback tag %0d", $time, wb.tag);
        end

    assert property (@(posedge clk) disable iff (reset)
                     wb.valid && wb.flags.exception |-> wb.destData == '0)
        else
        begin
            errCount++;
            $display("ERR %0t: exception with data %h", $time, wb.destData);
        end

    assert property (@(posedge clk) disable iff (reset) wb.valid |-> wb.flags.executed)
        else
        begin
            errCount++;
            $display("ERR %0t: executed flag missing on tag %0d", $time, wb.tag);
        end

    initial
    begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        idleCycles(3);  // output must stay quiet
        issueOp(MUL_H, 32'h8000_0000, 32'h8000_0000);
        issueOp(MULU_H, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issueOp(MUL_L, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        issueOp(MUL_H, 32'h8000_0000, 32'h7FFF_FFFF);
        for (int n = 0; n < N_RAND; n++)
            issueOp(opcode_e'(4'($unsigned($random(seed)) % 4)), pickOperand(), pickOperand());
        issueOp(DIV, 32'h8000_0000, 32'hFFFF_FFFF);  // overflow pair
        issueOp(REM, 32'h8000_0000, 32'hFFFF_FFFF);
        issueOp(DIV, -32'sd7, 32'd2);
        issueOp(REM, -32'sd7, 32'd2);
        issueOp(DIV, 32'd7, -32'sd2);
        issueOp(REM, 32'd7, -32'sd2);
        issueOp(DIVU, 32'hFFFF_FFFF, 32'd3);
        issueOp(REMU, 32'hFFFF_FFFF, 32'd3);
        for (int n = 0; n < N_RAND; n++)
            issueOp(opcode_e'(4'(4 + $unsigned($random(seed)) % 4)), pickOperand(),
                    pickOperand());
        issueOp(DIV, 32'd5, 32'd0);  // zero divisor traps
        issueOp(REMU, 32'd9, 32'd0);
        issueOp(SYSCALL, 32'd1, 32'd2);
        issueOp(opcode_e'(4'hB), 32'd3, 32'd4);  // illegal codes
        issueOp(opcode_e'(4'hF), 32'd3, 32'd4);
        issueOp(MULU_L, 32'd6, 32'd7);
        issueOp(DIV, 32'd100, 32'd9);
        recoverWith(REM, 32'd11, 32'd4);  // kills the last three too
        issueOp(MUL_L, 32'd3, 32'd5);
        issueOp(DIVU, 32'd64, 32'd8);
        issueOp(SYSCALL, 32'd0, 32'd0);
        idleCycles(ALU_DEPTH + 2);
        if (expQ.size() != 0)
        begin
            errCount++;
            $display("%0d expected writebacks never arrived", expQ.size());
        end
        $display("run complete with %0d errors", errCount);
        if (errCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // watchdog with a generous bound on the whole sequence
    initial
    begin
        #((NUM_OPS + ALU_DEPTH + 50) * PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: writebackPipe.sv
`default_nettype none
`timescale 1ns/1ps

module writebackPipe (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           recover_i,
    input  cplxAluPkg::ctrlPkt_t           ctrl_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  productLo_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  productHi_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  quotient_i,
    input  logic [cplxAluPkg::DATA_W-1:0]  remainder_i,
    output cplxAluPkg::wbPkt_t             wb_o
);
    import cplxAluPkg::*;

    ctrlPkt_t          ctrlPipe [ALU_DEPTH];  // stage 0 takes the issue
    ctrlPkt_t          lastCtrl;              // lines up with the unit outputs
    logic [DATA_W-1:0] selData;

    always_ff @(posedge clk)
    begin
        ctrlPipe[0] <= ctrl_i;
        for (int i = 1; i < ALU_DEPTH; i++)
        begin
            ctrlPipe[i] <= ctrlPipe[i-1];
        end
        // kill everything in flight plus the packet entering now
        if (reset || recover_i)
        begin
            for (int i = 0; i < ALU_DEPTH; i++)
            begin
                ctrlPipe[i].valid <= 1'b0;  // stage becomes a bubble
            end
        end
    end

    assign lastCtrl = ctrlPipe[ALU_DEPTH-1];

    // result mux at the last stage
    always_comb
    begin
        case (lastCtrl.resultSel)
            SEL_MUL_LO: selData = productLo_i;
            SEL_MUL_HI: selData = productHi_i;
            SEL_QUOT:   selData = quotient_i;
            SEL_REM:    selData = remainder_i;
            default:    selData = '0;  // SEL_NONE
        endcase
        if (lastCtrl.flags.exception)
        begin
            selData = '0;  // traps write 0
        end
    end

    always_comb
    begin
        wb_o = '0;  // idle bus is all zero
        if (lastCtrl.valid)
        begin
            wb_o.valid    = 1'b1;
            wb_o.tag      = lastCtrl.tag;
            wb_o.flags    = lastCtrl.flags;
            wb_o.destData = selData;
        end
    end

    // nothing survives a recovery edge
    assert property (@(posedge clk) disable iff (reset) recover_i |=> !wb_o.valid)
        else $error("writebackPipe: writeback right after recovery");

endmodule

`default_nettype wire
